// ==== hdl/axi_rand_consts.svh ====
`ifndef AXI_RAND_CONSTS_SVH
`define AXI_RAND_CONSTS_SVH

// bus widths
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define AXI_ID_W 4

// memory geometry, one word per offset
`define MEM_WORDS 16
`define MEM_OFS_W 4
`define ADDR_BASE 16'hca00 // only the bits above the word offset are compared

`define PROB_W 8
`define FIFO_DEPTH 4
`define IDLE_TIMEOUT 3 // cycles of quiet before o_idle

// xoroshiro start state, must not be all zero
`define PRNG_SEED0 64'h9e37_79b9_7f4a_7c15
`define PRNG_SEED1 64'hbf58_476d_1ce4_e5b9

`endif

// ==== hdl/axi_rand_pkg.sv ====
`default_nettype none

`include "axi_rand_consts.svh"

package axi_rand_pkg;

  // EXOKAY left out on purpose, AXI4-lite has no exclusive access
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]  id;
    logic [`MEM_OFS_W-1:0] ofs;
    logic                  decerr; // decoded when AW is accepted
  } aw_req_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } w_beat_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    axi_resp_e            resp;
  } b_rsp_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    axi_resp_e              resp;
    logic [`AXI_DATA_W-1:0] data;
  } r_rsp_t;

  // thresholds, 0 never fires
  typedef struct packed {
    logic [`PROB_W-1:0] aw_stall;
    logic [`PROB_W-1:0] w_stall;
    logic [`PROB_W-1:0] b_stall;
    logic [`PROB_W-1:0] ar_stall;
    logic [`PROB_W-1:0] r_stall;
    logic [`PROB_W-1:0] bresp_err;
    logic [`PROB_W-1:0] rresp_err;
    logic [`PROB_W-1:0] rdata_flip;
  } fault_prob_t;

  typedef struct packed {
    logic aw_stall;
    logic w_stall;
    logic b_stall;
    logic ar_stall;
    logic r_stall;
    logic bresp_err;
    logic rresp_err;
    logic rdata_flip;
    logic [$clog2(`AXI_DATA_W)-1:0] flip_pos; // bit to invert in read data
  } fault_do_t;

endpackage

`default_nettype wire

// ==== hdl/prng_xoroshiro.sv ====
`default_nettype none

`include "axi_rand_consts.svh"

module prng_xoroshiro (
  input  logic        i_clk,
  input  logic        i_rst_n,
  output logic [63:0] o_result
);

  logic [63:0] s0_q;
  logic [63:0] s1_q;
  logic [63:0] s0_nxt;
  logic [63:0] s1_nxt;
  logic [63:0] mix;

  function automatic logic [63:0] rotl(input logic [63:0] v, input int unsigned k);
    return (v << k) | (v >> (64 - k));
  endfunction

  // xoroshiro128+ step with rotations 24/16/37
  always_comb begin
    mix    = s0_q ^ s1_q;
    s0_nxt = rotl(s0_q, 24) ^ mix ^ (mix << 16);
    s1_nxt = rotl(mix, 37);
  end

  // seeded while in reset so every run repeats
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s0_q <= `PRNG_SEED0;
      s1_q <= `PRNG_SEED1;
    end else begin
      s0_q <= s0_nxt;
      s1_q <= s1_nxt;
    end
  end

  assign o_result = s0_q + s1_q; // the "+" output

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_push,
  input  logic             i_pop,
  input  logic [WIDTH-1:0] i_data,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // wraps at DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr_q] <= i_data;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (i_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (i_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (i_push && !i_pop)      count_q <= count_q + 1'b1;
      else if (i_pop && !i_push) count_q <= count_q - 1'b1;
    end
  end

  assign o_data  = mem[rd_ptr_q]; // head, valid while not empty
  assign o_empty = (count_q == '0);
  assign o_full  = (count_q == CNT_W'(DEPTH));

  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
  );
  a_no_underflow: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty
  );

endmodule

`default_nettype wire

// ==== hdl/fault_dice.sv ====
`default_nettype none

`include "axi_rand_consts.svh"

module fault_dice (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  axi_rand_pkg::fault_prob_t i_prob,
  output axi_rand_pkg::fault_do_t   o_do
);

  import axi_rand_pkg::*;

  localparam int FLIP_W = $clog2(`AXI_DATA_W);

  logic [63:0]              rnd;
  logic [7:0][`PROB_W-1:0]  slice; // one random byte per fault kind
  logic [7:0]               zero_thr;
  logic [7:0]               fired;

  // one generator shared by all eight decisions
  prng_xoroshiro u_prng (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .o_result (rnd)
  );

  assign slice = rnd[8*`PROB_W-1:0];

  // strict compare so a zero threshold can never win
  always_comb begin
    o_do.aw_stall   = i_prob.aw_stall   > slice[0];
    o_do.w_stall    = i_prob.w_stall    > slice[1];
    o_do.b_stall    = i_prob.b_stall    > slice[2];
    o_do.ar_stall   = i_prob.ar_stall   > slice[3];
    o_do.r_stall    = i_prob.r_stall    > slice[4];
    o_do.bresp_err  = i_prob.bresp_err  > slice[5];
    o_do.rresp_err  = i_prob.rresp_err  > slice[6];
    o_do.rdata_flip = i_prob.rdata_flip > slice[7];
    o_do.flip_pos   = slice[7][FLIP_W-1:0]; // low bits of the flip byte
  end

  assign fired = {o_do.aw_stall, o_do.w_stall, o_do.b_stall, o_do.ar_stall,
                  o_do.r_stall, o_do.bresp_err, o_do.rresp_err, o_do.rdata_flip};

  assign zero_thr = {i_prob.aw_stall == '0, i_prob.w_stall == '0,
                     i_prob.b_stall == '0, i_prob.ar_stall == '0,
                     i_prob.r_stall == '0, i_prob.bresp_err == '0,
                     i_prob.rresp_err == '0, i_prob.rdata_flip == '0};

  a_zero_never_fires: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (fired & zero_thr) == 8'd0
  );

endmodule

`default_nettype wire

// ==== hdl/slave_mem.sv ====
`default_nettype none

`include "axi_rand_consts.svh"

module slave_mem (
  input  logic                             i_clk,
  input  logic                             i_wr_en,
  input  logic [`MEM_OFS_W-1:0]            i_wr_ofs,
  input  axi_rand_pkg::w_beat_t            i_wr_beat,
  input  logic [`AXI_ADDR_W-1:0]           i_rd_addr,
  input  logic                             i_flip,
  input  logic [$clog2(`AXI_DATA_W)-1:0]   i_flip_pos,
  output logic                             o_rd_decerr,
  output logic [`AXI_DATA_W-1:0]           o_rd_data
);

  import axi_rand_pkg::*;

  localparam int OFS_LO = $clog2(`AXI_STRB_W);   // byte lane bits
  localparam int OFS_HI = OFS_LO + `MEM_OFS_W - 1;
  localparam logic [`AXI_ADDR_W-1:0] BASE = `ADDR_BASE;

  // contents undefined until written
  logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];

  logic [`MEM_OFS_W-1:0]  rd_ofs;
  logic [`AXI_DATA_W-1:0] rd_word;

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (i_wr_beat.strb[b]) mem[i_wr_ofs][8*b +: 8] <= i_wr_beat.data[8*b +: 8];
      end
    end
  end

  assign rd_ofs  = i_rd_addr[OFS_HI:OFS_LO];
  assign rd_word = mem[rd_ofs];

  // upper address bits must hit the base window
  assign o_rd_decerr = (i_rd_addr[`AXI_ADDR_W-1:OFS_HI+1] != BASE[`AXI_ADDR_W-1:OFS_HI+1]);

  always_comb begin
    o_rd_data = rd_word;
    if (i_flip) o_rd_data[i_flip_pos] = ~rd_word[i_flip_pos]; // single bit upset
  end

endmodule

`default_nettype wire

// ==== hdl/axi_rand_slave.sv ====
`default_nettype none

`include "axi_rand_consts.svh"

module axi_rand_slave (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic [`AXI_ID_W-1:0]      i_awid,
  input  logic [`AXI_ADDR_W-1:0]    i_awaddr,
  input  logic [2:0]                i_awprot, // accepted, not checked
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  logic [`AXI_DATA_W-1:0]    i_wdata,
  input  logic [`AXI_STRB_W-1:0]    i_wstrb,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  output logic [`AXI_ID_W-1:0]      o_bid,
  output logic [1:0]                o_bresp,
  output logic                      o_bvalid,
  input  logic                      i_bready,
  input  logic [`AXI_ID_W-1:0]      i_arid,
  input  logic [`AXI_ADDR_W-1:0]    i_araddr,
  input  logic [2:0]                i_arprot, // accepted, not checked
  input  logic                      i_arvalid,
  output logic                      o_arready,
  output logic [`AXI_ID_W-1:0]      o_rid,
  output logic [1:0]                o_rresp,
  output logic [`AXI_DATA_W-1:0]    o_rdata,
  output logic                      o_rvalid,
  input  logic                      i_rready,
  input  axi_rand_pkg::fault_prob_t i_prob,
  output logic                      o_busy,
  output logic                      o_idle,
  output logic                      o_stall
);

  import axi_rand_pkg::*;

  localparam int OFS_LO = $clog2(`AXI_STRB_W);
  localparam int OFS_HI = OFS_LO + `MEM_OFS_W - 1;
  localparam int IDLE_W = $clog2(`IDLE_TIMEOUT + 1);
  localparam logic [`AXI_ADDR_W-1:0] BASE = `ADDR_BASE;

  fault_do_t dice;
  aw_req_t   aw_in, aw_head;
  w_beat_t   w_in, w_head;
  b_rsp_t    b_in, b_head;
  r_rsp_t    r_in, r_head;
  logic aw_push, aw_empty, aw_full;
  logic w_push, w_empty, w_full;
  logic b_pop, b_empty, b_full;
  logic ar_push, r_pop, r_empty, r_full;
  logic commit;
  logic rd_decerr;
  logic [`AXI_DATA_W-1:0] rd_data;
  logic ready_en_q; // readies held low until out of reset
  logic bkeep_q;
  logic rkeep_q;
  logic [IDLE_W-1:0] idle_cnt_q;

  fault_dice u_dice (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_prob(i_prob), .o_do(dice));

  // request side
  assign o_awready = ready_en_q && !(dice.aw_stall || aw_full);
  assign o_wready  = ready_en_q && !(dice.w_stall || w_full);
  assign o_arready = ready_en_q && !(dice.ar_stall || r_full);
  assign aw_push   = i_awvalid && o_awready;
  assign w_push    = i_wvalid && o_wready;
  assign ar_push   = i_arvalid && o_arready;

  assign aw_in.id     = i_awid;
  assign aw_in.ofs    = i_awaddr[OFS_HI:OFS_LO];
  assign aw_in.decerr = (i_awaddr[`AXI_ADDR_W-1:OFS_HI+1] != BASE[`AXI_ADDR_W-1:OFS_HI+1]);
  assign w_in.data    = i_wdata;
  assign w_in.strb    = i_wstrb;

  sync_fifo #(.WIDTH($bits(aw_req_t)), .DEPTH(`FIFO_DEPTH)) u_aw_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(aw_push), .i_pop(commit),
    .i_data(aw_in), .o_data(aw_head), .o_empty(aw_empty), .o_full(aw_full));
  sync_fifo #(.WIDTH($bits(w_beat_t)), .DEPTH(`FIFO_DEPTH)) u_w_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(w_push), .i_pop(commit),
    .i_data(w_in), .o_data(w_head), .o_empty(w_empty), .o_full(w_full));

  // write engine pairs AW and W heads whenever B has room
  assign commit = !aw_empty && !w_empty && !b_full;

  always_comb begin
    b_in.id = aw_head.id;
    if (aw_head.decerr)      b_in.resp = DECERR;
    else if (dice.bresp_err) b_in.resp = SLVERR;
    else                     b_in.resp = OKAY;
  end

  slave_mem u_mem (
    .i_clk      (i_clk),
    .i_wr_en    (commit && !aw_head.decerr),
    .i_wr_ofs   (aw_head.ofs),
    .i_wr_beat  (w_head),
    .i_rd_addr  (i_araddr),
    .i_flip     (dice.rdata_flip),
    .i_flip_pos (dice.flip_pos),
    .o_rd_decerr(rd_decerr),
    .o_rd_data  (rd_data)
  );

  always_comb begin
    r_in.id   = i_arid;
    r_in.data = rd_data;
    if (rd_decerr)           r_in.resp = DECERR;
    else if (dice.rresp_err) r_in.resp = SLVERR;
    else                     r_in.resp = OKAY;
  end

  sync_fifo #(.WIDTH($bits(b_rsp_t)), .DEPTH(`FIFO_DEPTH)) u_b_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(commit), .i_pop(b_pop),
    .i_data(b_in), .o_data(b_head), .o_empty(b_empty), .o_full(b_full));
  sync_fifo #(.WIDTH($bits(r_rsp_t)), .DEPTH(`FIFO_DEPTH)) u_r_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(ar_push), .i_pop(r_pop),
    .i_data(r_in), .o_data(r_head), .o_empty(r_empty), .o_full(r_full));

  // response side, a raised valid ignores later stalls
  assign o_bvalid = !b_empty && (!dice.b_stall || bkeep_q);
  assign o_rvalid = !r_empty && (!dice.r_stall || rkeep_q);
  assign b_pop    = o_bvalid && i_bready;
  assign r_pop    = o_rvalid && i_rready;
  assign o_bid    = b_head.id;
  assign o_bresp  = b_head.resp;
  assign o_rid    = r_head.id;
  assign o_rresp  = r_head.resp;
  assign o_rdata  = r_head.data;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ready_en_q <= 1'b0;
      bkeep_q    <= 1'b0;
      rkeep_q    <= 1'b0;
      idle_cnt_q <= '0;
    end else begin
      ready_en_q <= 1'b1;
      bkeep_q    <= o_bvalid && !i_bready; // set on refused beat, clear on handshake
      rkeep_q    <= o_rvalid && !i_rready;
      if (o_busy)                idle_cnt_q <= IDLE_W'(`IDLE_TIMEOUT);
      else if (idle_cnt_q != '0) idle_cnt_q <= idle_cnt_q - 1'b1;
    end
  end

  assign o_busy  = !aw_empty || !w_empty || !b_empty || !r_empty;
  assign o_idle  = !o_busy && (idle_cnt_q == '0);
  assign o_stall = (!b_empty && dice.b_stall && !bkeep_q) ||
                   (!r_empty && dice.r_stall && !rkeep_q);

  a_bvalid_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp)
  );
  a_rvalid_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rid) && $stable(o_rdata)
  );

endmodule

`default_nettype wire

// ==== tests/tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// xorshift32 for master side stimulus
function automatic logic [31:0] next_rand();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

// a quarter period after the falling edge everything has settled
task automatic settle_outputs();
  #(CLK_PERIOD / 4);
endtask

// AW and W go out together, AR alone
task automatic send_request(input logic is_read, input logic [3:0] id,
                            input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
  int n;
  logic aw_hit, w_hit, ar_hit;
  n = 0;
  @(negedge clk);
  awid    = id;
  awaddr  = addr;
  wdata   = data;
  wstrb   = strb;
  arid    = id;
  araddr  = addr;
  awvalid = !is_read;
  wvalid  = !is_read;
  arvalid = is_read;
  while (awvalid || wvalid || arvalid) begin
    settle_outputs();
    aw_hit = awvalid && awready;
    w_hit  = wvalid && wready;
    ar_hit = arvalid && arready;
    if (n == WAIT_LIMIT)
      abort_run("request handshake never happened");
    n++;
    @(negedge clk);
    if (aw_hit)
      awvalid = 1'b0; // each valid drops after its own transfer
    if (w_hit)
      wvalid = 1'b0;
    if (ar_hit)
      arvalid = 1'b0;
  end
endtask

// ready may be throttled, the beat is taken at the next rising edge
task automatic take_response(input logic is_read, output logic [3:0] id,
                             output logic [1:0] resp, output logic [31:0] data);
  int n;
  logic [31:0] r;
  logic hit;
  n = 0;
  hit = 1'b0;
  while (!hit) begin
    @(negedge clk);
    r = next_rand();
    bready = !is_read && (!throttle || r[0]);
    rready = is_read && (!throttle || r[0]);
    settle_outputs();
    hit  = is_read ? (rvalid && rready) : (bvalid && bready);
    id   = is_read ? rid : bid;
    resp = is_read ? rresp : bresp;
    data = rdata;
    if (!hit && n == WAIT_LIMIT)
      abort_run("response valid never met its ready");
    n++;
  end
  @(negedge clk);
  bready = 1'b0;
  rready = 1'b0;
endtask

`endif

// ==== tests/tb_axi_rand_slave.sv ====
`default_nettype none

`include "axi_rand_consts.svh"

module tb_axi_rand_slave;

  import axi_rand_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int WAIT_LIMIT = 5000; // max stall dice fire 255 times in 256
  localparam logic [15:0] BASE = `ADDR_BASE;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  awid, arid, bid, rid;
  logic [15:0] awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic        awready, wready, bvalid, arready, rvalid;
  logic        busy, idle, stall;
  fault_prob_t prob;

  logic [31:0] rng_state;
  logic [31:0] shadow [`MEM_WORDS]; // expected memory contents
  logic        throttle;
  logic        stall_seen;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_rand_slave dut_i (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_awid(awid), .i_awaddr(awaddr), .i_awprot(3'b000), .i_awvalid(awvalid),
    .o_awready(awready),
    .i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
    .o_bid(bid), .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
    .i_arid(arid), .i_araddr(araddr), .i_arprot(3'b000), .i_arvalid(arvalid),
    .o_arready(arready),
    .o_rid(rid), .o_rresp(rresp), .o_rdata(rdata), .o_rvalid(rvalid), .i_rready(rready),
    .i_prob(prob), .o_busy(busy), .o_idle(idle), .o_stall(stall)
  );

  task automatic note_failure(input string what);
    $display("%s", what);
    errors++;
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else note_failure($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond)
      else note_failure(what);
  endtask

  `include "tb_axi_tasks.svh"

  // response valids keep their payload until the master takes them
  a_bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
    else note_failure("o_bvalid dropped or changed before i_bready");
  a_rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rid) && $stable(rresp) && $stable(rdata))
    else note_failure("o_rvalid dropped or changed before i_rready");

  always @(posedge clk) begin
    if (!rst_n)
      stall_seen <= 1'b0;
    else if (stall)
      stall_seen <= 1'b1;
  end

  function automatic logic [15:0] word_addr(input logic [3:0] ofs);
    return BASE | {10'd0, ofs, 2'b00};
  endfunction

  // bits 15:6 select the memory window
  function automatic logic in_range(input logic [15:0] addr);
    return addr[15:6] == BASE[15:6];
  endfunction

  function automatic logic [31:0] merge_strb(input logic [31:0] old,
                                             input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    settle_outputs();
    expect_equal("o_awready", 32'(awready), 32'd0); // request side closed in reset
    expect_equal("o_wready", 32'(wready), 32'd0);
    expect_equal("o_arready", 32'(arready), 32'd0);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [3:0] strb,
                            output logic [1:0] resp);
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] unused;
    logic [3:0]  got_id;
    r = next_rand();
    data = next_rand();
    send_request(1'b0, r[3:0], addr, data, strb);
    take_response(1'b0, got_id, resp, unused);
    expect_equal("o_bid", 32'(got_id), 32'(r[3:0]));
    if (in_range(addr))
      shadow[addr[5:2]] = merge_strb(shadow[addr[5:2]], data, strb); // DECERR leaves memory
  endtask

  task automatic read_word(input logic [15:0] addr, output logic [1:0] resp,
                           output logic [31:0] data);
    logic [31:0] r;
    logic [3:0]  got_id;
    r = next_rand();
    send_request(1'b1, r[3:0], addr, 32'd0, 4'd0);
    take_response(1'b1, got_id, resp, data);
    expect_equal("o_rid", 32'(got_id), 32'(r[3:0]));
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests++;
    if (errors == err_mark)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_mark);
  endtask

  initial begin : run_tests
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] r;
    logic [3:0]  ofs;
    logic [3:0]  id;
    int err_mark;
    int slverr_cnt;
    int flip_cnt;
    int n;
    rng_state = 32'h826e_fef2;
    throttle = 1'b0;
    prob = '0;
    {awid, awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {arid, araddr, arvalid, rready} = '0;
    apply_reset();

    err_mark = errors;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      write_word(word_addr(4'(i)), 4'hf, resp); // defined contents first
      expect_equal("o_bresp", 32'(resp), 32'(OKAY));
    end
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      write_word(word_addr(r[3:0]), r[7:4], resp);
      expect_equal("o_bresp", 32'(resp), 32'(OKAY));
    end
    for (int i = 0; i < `MEM_WORDS; i++) begin
      read_word(word_addr(4'(i)), resp, data);
      expect_equal("o_rresp", 32'(resp), 32'(OKAY));
      expect_equal("o_rdata", data, shadow[i]);
    end
    finish_test("basic", err_mark);

    err_mark = errors;
    r = next_rand();
    ofs = r[3:0];
    write_word(word_addr(ofs) ^ 16'h8000, 4'hf, resp);
    expect_equal("o_bresp", 32'(resp), 32'(DECERR));
    write_word(word_addr(ofs) ^ 16'h0040, 4'hf, resp); // lowest decoded bit
    expect_equal("o_bresp", 32'(resp), 32'(DECERR));
    read_word(word_addr(ofs) ^ 16'h0400, resp, data);
    expect_equal("o_rresp", 32'(resp), 32'(DECERR));
    read_word(word_addr(ofs), resp, data);
    expect_equal("o_rresp", 32'(resp), 32'(OKAY));
    expect_equal("o_rdata", data, shadow[ofs]);
    finish_test("decode", err_mark);

    err_mark = errors;
    prob.aw_stall = 8'hff;
    prob.w_stall = 8'hff;
    prob.b_stall = 8'hff;
    prob.ar_stall = 8'hff;
    prob.r_stall = 8'hff;
    throttle = 1'b1;
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      write_word(word_addr(r[3:0]), r[7:4], resp);
      expect_equal("o_bresp", 32'(resp), 32'(OKAY));
      read_word(word_addr(r[11:8]), resp, data);
      expect_equal("o_rresp", 32'(resp), 32'(OKAY));
      expect_equal("o_rdata", data, shadow[r[11:8]]);
    end
    expect_true(stall_seen, "o_stall never rose under maximum stall thresholds");
    finish_test("stalls", err_mark);

    err_mark = errors;
    prob = '0;
    prob.bresp_err = 8'hff;
    prob.rresp_err = 8'hff;
    prob.rdata_flip = 8'hff;
    throttle = 1'b0;
    slverr_cnt = 0;
    flip_cnt = 0;
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      write_word(word_addr(r[3:0]), r[7:4], resp);
      expect_true(resp == OKAY || resp == SLVERR, "in-range write answered DECERR");
      slverr_cnt += int'(resp == SLVERR);
    end
    for (int i = 0; i < `MEM_WORDS; i++) begin
      read_word(word_addr(4'(i)), resp, data);
      expect_true(resp == OKAY || resp == SLVERR, "in-range read answered DECERR");
      expect_true($countones(data ^ shadow[i]) <= 1, "read data off by more than one bit");
      slverr_cnt += int'(resp == SLVERR);
      flip_cnt += int'(data != shadow[i]);
    end
    expect_true(slverr_cnt > 0, "no SLVERR seen with error thresholds at maximum");
    expect_true(flip_cnt > 0, "no flipped read data seen with flip threshold at maximum");
    finish_test("errors", err_mark);

    err_mark = errors;
    prob = '0;
    apply_reset();
    settle_outputs();
    expect_equal("o_idle", 32'(idle), 32'd1);
    expect_equal("o_busy", 32'(busy), 32'd0);
    expect_equal("o_stall", 32'(stall), 32'd0);
    expect_equal("o_bvalid", 32'(bvalid), 32'd0);
    expect_equal("o_rvalid", 32'(rvalid), 32'd0);
    send_request(1'b1, 4'h5, word_addr(4'h3), 32'd0, 4'd0);
    settle_outputs();
    n = 0;
    while (!rvalid) begin
      if (n == WAIT_LIMIT)
        abort_run("o_rvalid never rose after the read request");
      n++;
      @(negedge clk);
      settle_outputs();
    end
    repeat (3) begin // response held back by rready low
      expect_equal("o_busy", 32'(busy), 32'd1);
      expect_equal("o_idle", 32'(idle), 32'd0);
      @(negedge clk);
      settle_outputs();
    end
    take_response(1'b1, id, resp, data);
    expect_equal("o_rid", 32'(id), 32'h5);
    expect_equal("o_rresp", 32'(resp), 32'(OKAY));
    expect_equal("o_rdata", data, shadow[3]);
    settle_outputs();
    n = 0;
    while (busy) begin
      if (n == WAIT_LIMIT)
        abort_run("o_busy never fell after the last handshake");
      n++;
      @(negedge clk);
      settle_outputs();
    end
    n = 0; // counts cycles from the first quiet one
    while (!idle) begin
      if (n == WAIT_LIMIT)
        abort_run("o_idle never rose after the bus went quiet");
      n++;
      @(negedge clk);
      settle_outputs();
    end
    expect_equal("o_idle delay", 32'(n), 32'(`IDLE_TIMEOUT));
    finish_test("idle", err_mark);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
+incdir+tests
hdl/axi_rand_pkg.sv
hdl/prng_xoroshiro.sv
hdl/sync_fifo.sv
hdl/fault_dice.sv
hdl/slave_mem.sv
hdl/axi_rand_slave.sv
tests/tb_axi_rand_slave.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-lite fault-injecting responder

VERILATOR ?= verilator
TOP       ?= tb_axi_rand_slave
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh tests/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "TB FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
